// ==== include/pcr_defines.svh ====
`ifndef PCR_DEFINES_SVH
`define PCR_DEFINES_SVH

// ------------------------------------------------------------
// Sizes
// ------------------------------------------------------------

// Peripherals with a control slice
`define PCR_NUM_PERIPH 9

// Word index taken from byte address bits 6:2
`define PCR_IDX_W 5

`define PCR_DATA_W 32

`define PCR_CLK_SEL_W 3

// ------------------------------------------------------------
// Register map, word offsets
// ------------------------------------------------------------

`define PCR_OFS_ID 5'd0

// Clock select of peripheral i sits at base + i
`define PCR_OFS_CLK_SEL_BASE 5'd1

`define PCR_OFS_GATE_EN 5'd16
`define PCR_OFS_RESET_REQ 5'd17
`define PCR_OFS_RESET_ACK 5'd18

// Read-only identification word
`define PCR_ID_VALUE 32'h5A5A5A5A

`endif

// ==== verilog/pcr_pkg.sv ====
`include "pcr_defines.svh"

package pcr_pkg;

  // ------------------------------------------------------------
  // Peripheral numbering
  // ------------------------------------------------------------

  // Also the bit position in the gate, request and ack vectors
  typedef enum logic [3:0] {
    DMA0    = 4'd0,
    DMA1    = 4'd1,
    TLX_FWD = 4'd2,
    CGRA    = 4'd3,
    TIMER0  = 4'd4,
    TIMER1  = 4'd5,
    UART0   = 4'd6,
    UART1   = 4'd7,
    WDOG    = 4'd8
  } periph_e;

  typedef logic [`PCR_CLK_SEL_W-1:0] clk_sel_t;

  // ------------------------------------------------------------
  // Register data word
  // ------------------------------------------------------------

  // Clock select register layout
  typedef struct packed {
    logic [`PCR_DATA_W-`PCR_CLK_SEL_W-1:0] rsvd;
    clk_sel_t                              sel;
  } clk_sel_word_t;

  // One bit per peripheral, indexed by periph_e
  typedef struct packed {
    logic [`PCR_DATA_W-`PCR_NUM_PERIPH-1:0] rsvd;
    logic [`PCR_NUM_PERIPH-1:0]             mask;
  } periph_word_t;

  typedef union packed {
    clk_sel_word_t clk_sel_word;
    periph_word_t  periph_word;
  } reg_word_u;

  // ------------------------------------------------------------
  // Per-peripheral control outputs
  // ------------------------------------------------------------

  typedef struct packed {
    clk_sel_t clk_sel;
    logic     clk_gate_en;
    logic     reset_req;
  } slice_state_t;

  // UART0 comes up on source 1, everything else on source 5
  localparam clk_sel_t CLK_SEL_RESET [`PCR_NUM_PERIPH] = '{
    3'd5,  // DMA0
    3'd5,  // DMA1
    3'd5,  // TLX_FWD
    3'd5,  // CGRA
    3'd5,  // TIMER0
    3'd5,  // TIMER1
    3'd1,  // UART0
    3'd5,  // UART1
    3'd5   // WDOG
  };

endpackage

// ==== verilog/ahb_pkg.sv ====
`include "pcr_defines.svh"

package ahb_pkg;

  // ------------------------------------------------------------
  // AHB transfer type
  // ------------------------------------------------------------

  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    BUSY   = 2'b01,
    NONSEQ = 2'b10,
    SEQ    = 2'b11
  } htrans_t;

  // ------------------------------------------------------------
  // Register write command, valid for one data phase
  // ------------------------------------------------------------

  typedef struct packed {
    logic                    valid;
    logic [`PCR_IDX_W-1:0]   index;
    pcr_pkg::reg_word_u      data;
  } reg_wr_t;

endpackage

// ==== verilog/pcr_ahb_frontend.sv ====
`timescale 1ns/1ps

`include "pcr_defines.svh"

module pcr_ahb_frontend (
  input  logic                  HCLK,
  input  logic                  HRESETn,
  input  logic                  hsel,
  input  logic [31:0]           haddr,
  input  ahb_pkg::htrans_t      htrans,
  input  logic                  hwrite,
  input  logic                  hready,
  input  logic [31:0]           hwdata,
  output ahb_pkg::reg_wr_t      wr,
  output logic [`PCR_IDX_W-1:0] rd_index
);

  import ahb_pkg::*;

  // Unmapped offset, keeps hrdata at zero until the first transfer
  localparam logic [`PCR_IDX_W-1:0] IDX_IDLE = '1;

  logic                  accept;
  logic                  wr_pend_q;
  logic [`PCR_IDX_W-1:0] idx_q;

  // ------------------------------------------------------------
  // Address phase
  // ------------------------------------------------------------

  assign accept = hsel && hready && ((htrans == NONSEQ) || (htrans == SEQ));

  // Only sample when the bus moves on, a stalled data phase keeps its
  // pending write and index
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      wr_pend_q <= 1'b0;
      idx_q     <= IDX_IDLE;
    end else if (hready) begin
      wr_pend_q <= accept && hwrite;
      if (accept) begin
        idx_q <= haddr[`PCR_IDX_W+1:2];
      end
    end
  end

  // ------------------------------------------------------------
  // Data phase
  // ------------------------------------------------------------

  // Write issued in the cycle that completes the data phase
  always_comb begin
    wr.valid = wr_pend_q && hready;
    wr.index = idx_q;
    wr.data  = hwdata;
  end

  // Last accepted index drives the read mux
  assign rd_index = idx_q;

endmodule

// ==== verilog/pcr_periph_slice.sv ====
`timescale 1ns/1ps

`include "pcr_defines.svh"

module pcr_periph_slice #(
  parameter pcr_pkg::periph_e  PERIPH_IDX    = pcr_pkg::DMA0,
  parameter pcr_pkg::clk_sel_t RESET_CLK_SEL = 3'd5
) (
  input  logic                  HCLK,
  input  logic                  HRESETn,
  input  ahb_pkg::reg_wr_t      wr,
  output pcr_pkg::slice_state_t state
);

  import pcr_pkg::*;

  // Own clock select offset
  localparam logic [`PCR_IDX_W-1:0] SEL_OFS =
    `PCR_OFS_CLK_SEL_BASE + `PCR_IDX_W'(PERIPH_IDX);

  clk_sel_t clk_sel_q;
  logic     gate_en_q;
  logic     reset_req_q;

  // ------------------------------------------------------------
  // Control registers
  // ------------------------------------------------------------

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      clk_sel_q   <= RESET_CLK_SEL;
      gate_en_q   <= 1'b1;
      reset_req_q <= 1'b1;
    end else if (wr.valid) begin
      if (wr.index == SEL_OFS) begin
        clk_sel_q <= wr.data.clk_sel_word.sel;
      end
      // Shared vectors, this slice owns one bit
      if (wr.index == `PCR_OFS_GATE_EN) begin
        gate_en_q <= wr.data.periph_word.mask[PERIPH_IDX];
      end
      if (wr.index == `PCR_OFS_RESET_REQ) begin
        reset_req_q <= wr.data.periph_word.mask[PERIPH_IDX];
      end
    end
  end

  assign state = '{
    clk_sel:     clk_sel_q,
    clk_gate_en: gate_en_q,
    reset_req:   reset_req_q
  };

endmodule

// ==== verilog/pcr_readback.sv ====
`timescale 1ns/1ps

`include "pcr_defines.svh"

module pcr_readback (
  input  logic [`PCR_IDX_W-1:0]                             rd_index,
  input  pcr_pkg::slice_state_t [`PCR_NUM_PERIPH-1:0]       slices,
  input  logic [`PCR_NUM_PERIPH-1:0]                        reset_ack,
  output logic [31:0]                                       hrdata
);

  import pcr_pkg::*;

  logic [`PCR_NUM_PERIPH-1:0] gate_vec;
  logic [`PCR_NUM_PERIPH-1:0] req_vec;
  reg_word_u                  rd_word;

  // ------------------------------------------------------------
  // Gather per-slice bits into vectors
  // ------------------------------------------------------------

  always_comb begin
    for (int i = 0; i < `PCR_NUM_PERIPH; i++) begin
      gate_vec[i] = slices[i].clk_gate_en;
      req_vec[i]  = slices[i].reset_req;
    end
  end

  // ------------------------------------------------------------
  // Read mux
  // ------------------------------------------------------------

  always_comb begin
    rd_word = '0;
    case (rd_index)
      `PCR_OFS_ID:        rd_word = `PCR_ID_VALUE;
      `PCR_OFS_GATE_EN:   rd_word.periph_word.mask = gate_vec;
      `PCR_OFS_RESET_REQ: rd_word.periph_word.mask = req_vec;
      `PCR_OFS_RESET_ACK: rd_word.periph_word.mask = reset_ack;
      default: begin
        // Clock select block, anything outside it reads zero
        for (int i = 0; i < `PCR_NUM_PERIPH; i++) begin
          if (rd_index == `PCR_OFS_CLK_SEL_BASE + i[`PCR_IDX_W-1:0]) begin
            rd_word.clk_sel_word.sel = slices[i].clk_sel;
          end
        end
      end
    endcase
  end

  assign hrdata = rd_word;

endmodule

// ==== verilog/pcr_top.sv ====
`timescale 1ns/1ps

`include "pcr_defines.svh"

module pcr_top (
  input  logic                                        HCLK,
  input  logic                                        HRESETn,

  // AHB-Lite slave
  input  logic                                        hsel,
  input  logic [31:0]                                 haddr,
  input  ahb_pkg::htrans_t                            htrans,
  input  logic                                        hwrite,
  input  logic [31:0]                                 hwdata,
  input  logic                                        hready,
  output logic [31:0]                                 hrdata,
  output logic                                        hreadyout,
  output logic                                        hresp,

  // Peripheral side
  input  logic [`PCR_NUM_PERIPH-1:0]                  reset_ack,
  output pcr_pkg::slice_state_t [`PCR_NUM_PERIPH-1:0] periph_ctrl
);

  import ahb_pkg::*;
  import pcr_pkg::*;

  reg_wr_t               wr;
  logic [`PCR_IDX_W-1:0] rd_index;

  // ------------------------------------------------------------
  // Bus front end
  // ------------------------------------------------------------

  pcr_ahb_frontend u_frontend (
    .HCLK     (HCLK),
    .HRESETn  (HRESETn),
    .hsel     (hsel),
    .haddr    (haddr),
    .htrans   (htrans),
    .hwrite   (hwrite),
    .hready   (hready),
    .hwdata   (hwdata),
    .wr       (wr),
    .rd_index (rd_index)
  );

  // Zero wait states, never an error
  assign hreadyout = 1'b1;
  // OKAY
  assign hresp     = 1'b0;

  // ------------------------------------------------------------
  // One control slice per peripheral
  // ------------------------------------------------------------

  for (genvar i = 0; i < `PCR_NUM_PERIPH; i++) begin : g_slice
    pcr_periph_slice #(
      .PERIPH_IDX    (periph_e'(i)),
      .RESET_CLK_SEL (CLK_SEL_RESET[i])
    ) u_slice (
      .HCLK    (HCLK),
      .HRESETn (HRESETn),
      .wr      (wr),
      .state   (periph_ctrl[i])
    );
  end

  // ------------------------------------------------------------
  // Read data
  // ------------------------------------------------------------

  pcr_readback u_readback (
    .rd_index  (rd_index),
    .slices    (periph_ctrl),
    .reset_ack (reset_ack),
    .hrdata    (hrdata)
  );

endmodule

// ==== verif/tb_pcr_top.sv ====
`timescale 1ns/1ps

`include "pcr_defines.svh"

module tb_pcr_top;

  import ahb_pkg::*;
  import pcr_pkg::*;

  localparam int          READY_TIMEOUT = 16;
  localparam logic [31:0] BASE_ADDR     = 32'h4002_0000;
  localparam logic [31:0] LFSR_SEED     = 32'h83467b01;

  logic                                        HCLK;
  logic                                        HRESETn;
  logic                                        hsel;
  logic [31:0]                                 haddr;
  htrans_t                                     htrans;
  logic                                        hwrite;
  logic [31:0]                                 hwdata;
  logic                                        hready;
  logic [31:0]                                 hrdata;
  logic                                        hreadyout;
  logic                                        hresp;
  logic [`PCR_NUM_PERIPH-1:0]                  reset_ack;
  slice_state_t [`PCR_NUM_PERIPH-1:0]          periph_ctrl;

  int           errors;
  int           checks;
  logic [31:0]  lfsr_state;
  // Expected periph_ctrl as tracked across writes
  slice_state_t exp_state [`PCR_NUM_PERIPH];

  pcr_top pcr_top_i (
    .HCLK        (HCLK),
    .HRESETn     (HRESETn),
    .hsel        (hsel),
    .haddr       (haddr),
    .htrans      (htrans),
    .hwrite      (hwrite),
    .hwdata      (hwdata),
    .hready      (hready),
    .hrdata      (hrdata),
    .hreadyout   (hreadyout),
    .hresp       (hresp),
    .reset_ack   (reset_ack),
    .periph_ctrl (periph_ctrl)
  );

  initial begin
    HCLK = 1'b0;
    forever #50 HCLK = ~HCLK;
  end

  // ------------------------------------------------------------
  // Stimulus helpers
  // ------------------------------------------------------------

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] lfsr_word(int nbits);
    logic [31:0] w;
    w = '0;
    for (int i = 0; i < nbits; i++) begin
      w = {w[30:0], lfsr_bit()};
    end
    return w;
  endfunction

  function automatic logic [31:0] reg_addr(logic [`PCR_IDX_W-1:0] idx);
    return BASE_ADDR | {25'd0, idx, 2'b00};
  endfunction

  function automatic clk_sel_t reset_sel(int p);
    return (p == int'(UART0)) ? 3'd1 : 3'd5;
  endfunction

  function automatic reg_word_u sel_word(clk_sel_t s);
    reg_word_u w;
    w = '0;
    w.clk_sel_word.sel = s;
    return w;
  endfunction

  function automatic reg_word_u mask_word(logic [`PCR_NUM_PERIPH-1:0] m);
    reg_word_u w;
    w = '0;
    w.periph_word.mask = m;
    return w;
  endfunction

  // ------------------------------------------------------------
  // AHB tasks
  // ------------------------------------------------------------

  task automatic addr_phase(logic [31:0] addr, logic write);
    hsel   = 1'b1;
    haddr  = addr;
    htrans = NONSEQ;
    hwrite = write;
  endtask

  task automatic bus_idle();
    hsel   = 1'b0;
    htrans = IDLE;
    hwrite = 1'b0;
  endtask

  // Ends the current bus cycle once hreadyout is high and returns 1 ns after the edge
  task automatic complete_phase(output logic [31:0] rdata);
    int waited;
    waited = 0;
    @(negedge HCLK);
    while (hreadyout !== 1'b1 && waited < READY_TIMEOUT) begin
      waited++;
      @(negedge HCLK);
    end
    if (hreadyout !== 1'b1) begin
      $display("Timeout: hreadyout stayed low for %0d cycles at %0t", READY_TIMEOUT, $time);
      $display("Simulation FAILED");
      $finish;
    end else begin
      rdata = hrdata;
      check_resp("hresp", hresp);
      @(posedge HCLK);
      #1;
    end
  endtask

  task automatic ahb_write(logic [31:0] addr, logic [31:0] data);
    logic [31:0] unused;
    addr_phase(addr, 1'b1);
    complete_phase(unused);
    bus_idle();
    hwdata = data;
    complete_phase(unused);
  endtask

  task automatic ahb_read(logic [31:0] addr, output logic [31:0] data);
    logic [31:0] unused;
    addr_phase(addr, 1'b0);
    complete_phase(unused);
    bus_idle();
    complete_phase(data);
  endtask

  // Read address phase overlaps the write data phase
  task automatic write_then_read(logic [31:0] addr, logic [31:0] data,
                                 output logic [31:0] rdata);
    logic [31:0] unused;
    addr_phase(addr, 1'b1);
    complete_phase(unused);
    hwdata = data;
    addr_phase(addr, 1'b0);
    complete_phase(unused);
    bus_idle();
    complete_phase(rdata);
  endtask

  // ------------------------------------------------------------
  // Compare tasks
  // ------------------------------------------------------------

  task automatic check_word(string what, reg_word_u got, reg_word_u exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_state(string what, slice_state_t got, slice_state_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED at %0t: %s got sel %0d gate %b req %b expected sel %0d gate %b req %b",
               $time, what, got.clk_sel, got.clk_gate_en, got.reset_req,
               exp.clk_sel, exp.clk_gate_en, exp.reset_req);
    end
  endtask

  task automatic check_ack(string what, logic [`PCR_NUM_PERIPH-1:0] got,
                           logic [`PCR_NUM_PERIPH-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED at %0t: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  // Every transfer ends with an OKAY response
  task automatic check_resp(string what, logic got);
    checks++;
    if (got !== 1'b0) begin
      errors++;
      $display("FAILED at %0t: %s got %b expected OKAY", $time, what, got);
    end
  endtask

  task automatic check_outputs(string what);
    for (int i = 0; i < `PCR_NUM_PERIPH; i++) begin
      check_state($sformatf("%s periph_ctrl[%0d]", what, i), periph_ctrl[i], exp_state[i]);
    end
  endtask

  // ------------------------------------------------------------
  // Tests
  // ------------------------------------------------------------

  task automatic test_reset_values();
    logic [31:0] rd;
    check_word("hrdata after reset", hrdata, '0);
    for (int p = 0; p < `PCR_NUM_PERIPH; p++) begin
      exp_state[p] = '{clk_sel: reset_sel(p), clk_gate_en: 1'b1, reset_req: 1'b1};
    end
    check_outputs("reset");
    for (int p = 0; p < `PCR_NUM_PERIPH; p++) begin
      ahb_read(reg_addr(`PCR_OFS_CLK_SEL_BASE + 5'(p)), rd);
      check_word($sformatf("reset clk_sel[%0d]", p), rd, sel_word(reset_sel(p)));
    end
    ahb_read(reg_addr(`PCR_OFS_GATE_EN), rd);
    check_word("reset gate_en", rd, mask_word('1));
    ahb_read(reg_addr(`PCR_OFS_RESET_REQ), rd);
    check_word("reset reset_req", rd, mask_word('1));
  endtask

  task automatic test_identification();
    logic [31:0] rd;
    ahb_read(reg_addr(`PCR_OFS_ID), rd);
    check_word("id", rd, `PCR_ID_VALUE);
    // Map repeats every 128 bytes
    ahb_read(reg_addr(`PCR_OFS_ID) + 32'd128, rd);
    check_word("id alias", rd, `PCR_ID_VALUE);
    ahb_write(reg_addr(`PCR_OFS_ID), lfsr_word(32));
    ahb_read(reg_addr(`PCR_OFS_ID), rd);
    check_word("id after write", rd, `PCR_ID_VALUE);
    check_outputs("id write");
  endtask

  task automatic test_clock_select();
    logic [31:0] w;
    logic [31:0] rd;
    for (int p = 0; p < `PCR_NUM_PERIPH; p++) begin
      w = lfsr_word(32);
      ahb_write(reg_addr(`PCR_OFS_CLK_SEL_BASE + 5'(p)), w);
      exp_state[p].clk_sel = w[`PCR_CLK_SEL_W-1:0];
      check_outputs($sformatf("clk_sel write %0d", p));
      ahb_read(reg_addr(`PCR_OFS_CLK_SEL_BASE + 5'(p)), rd);
      check_word($sformatf("clk_sel[%0d]", p), rd, sel_word(w[`PCR_CLK_SEL_W-1:0]));
    end
  endtask

  task automatic test_enable_vectors();
    logic [31:0] m;
    logic [31:0] rd;
    repeat (4) begin
      m = lfsr_word(32);
      ahb_write(reg_addr(`PCR_OFS_GATE_EN), m);
      for (int p = 0; p < `PCR_NUM_PERIPH; p++) exp_state[p].clk_gate_en = m[p];
      check_outputs("gate_en write");
      ahb_read(reg_addr(`PCR_OFS_GATE_EN), rd);
      check_word("gate_en", rd, mask_word(m[`PCR_NUM_PERIPH-1:0]));
      m = lfsr_word(32);
      ahb_write(reg_addr(`PCR_OFS_RESET_REQ), m);
      for (int p = 0; p < `PCR_NUM_PERIPH; p++) exp_state[p].reset_req = m[p];
      check_outputs("reset_req write");
      ahb_read(reg_addr(`PCR_OFS_RESET_REQ), rd);
      check_word("reset_req", rd, mask_word(m[`PCR_NUM_PERIPH-1:0]));
    end
  endtask

  task automatic test_acknowledge();
    logic [`PCR_NUM_PERIPH-1:0] a;
    logic [31:0]                rd;
    repeat (4) begin
      a = lfsr_word(`PCR_NUM_PERIPH);
      reset_ack = a;
      ahb_read(reg_addr(`PCR_OFS_RESET_ACK), rd);
      check_ack("reset_ack", rd[`PCR_NUM_PERIPH-1:0], a);
      check_word("reset_ack word", rd, mask_word(a));
      ahb_write(reg_addr(`PCR_OFS_RESET_ACK), lfsr_word(32));
      check_outputs("reset_ack write");
      ahb_read(reg_addr(`PCR_OFS_RESET_ACK), rd);
      check_ack("reset_ack after write", rd[`PCR_NUM_PERIPH-1:0], a);
    end
  endtask

  task automatic probe_unmapped(int ofs);
    logic [31:0] rd;
    ahb_read(reg_addr(5'(ofs)), rd);
    check_word($sformatf("unmapped read %0d", ofs), rd, '0);
    ahb_write(reg_addr(5'(ofs)), lfsr_word(32));
    check_outputs($sformatf("unmapped write %0d", ofs));
  endtask

  task automatic test_unmapped_and_pipeline();
    logic [31:0] w;
    logic [31:0] rd;
    for (int ofs = 10; ofs <= 15; ofs++) probe_unmapped(ofs);
    for (int ofs = 19; ofs <= 31; ofs++) probe_unmapped(ofs);
    w = lfsr_word(32);
    write_then_read(reg_addr(`PCR_OFS_CLK_SEL_BASE + 5'(TIMER1)), w, rd);
    exp_state[TIMER1].clk_sel = w[`PCR_CLK_SEL_W-1:0];
    check_word("back-to-back clk_sel", rd, sel_word(w[`PCR_CLK_SEL_W-1:0]));
    w = lfsr_word(32);
    write_then_read(reg_addr(`PCR_OFS_GATE_EN), w, rd);
    for (int p = 0; p < `PCR_NUM_PERIPH; p++) exp_state[p].clk_gate_en = w[p];
    check_word("back-to-back gate_en", rd, mask_word(w[`PCR_NUM_PERIPH-1:0]));
    check_outputs("back-to-back");
  endtask

  // ------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------

  initial begin
    errors     = 0;
    checks     = 0;
    lfsr_state = LFSR_SEED;
    HRESETn    = 1'b0;
    hsel       = 1'b0;
    haddr      = '0;
    htrans     = IDLE;
    hwrite     = 1'b0;
    hwdata     = '0;
    hready     = 1'b1;
    reset_ack  = '0;
    repeat (4) @(posedge HCLK);
    #1;
    HRESETn = 1'b1;

    test_reset_values();
    test_identification();
    test_clock_select();
    test_enable_vectors();
    test_acknowledge();
    test_unmapped_and_pipeline();

    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// ==== sources.f ====
+incdir+include
verilog/pcr_pkg.sv
verilog/ahb_pkg.sv
verilog/pcr_ahb_frontend.sv
verilog/pcr_periph_slice.sv
verilog/pcr_readback.sv
verilog/pcr_top.sv
verif/tb_pcr_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the PCR testbench with Verilator, fail on the fail message in the log
cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -f "$LOG"

verilator --binary --timing -Wno-fatal -j 0 \
  --top-module tb_pcr_top -f sources.f -o tb_pcr_top \
  && ./obj_dir/tb_pcr_top > "$LOG" 2>&1 \
  || { cat "$LOG" 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }

cat "$LOG"
grep -q "Simulation FAILED" "$LOG" && exit 1
exit 0
